// File: rv_core_pkg.sv
package rv_core_pkg;

  localparam int unsigned xlen       = 32;  // Data and address width
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned num_regs   = 32;
  localparam int unsigned insn_step  = 4;   // Bytes per instruction

  // Major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    op_load     = 7'b00_000_11,
    op_store    = 7'b01_000_11,
    op_branch   = 7'b11_000_11,
    op_jalr     = 7'b11_001_11,
    op_misc_mem = 7'b00_011_11,  // FENCE
    op_jal      = 7'b11_011_11,
    op_reg_imm  = 7'b00_100_11,
    op_reg_reg  = 7'b01_100_11,
    op_environ  = 7'b11_100_11,  // ECALL
    op_lui      = 7'b01_101_11
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10   // Operand B straight through
  } alu_op_e;

  // Branch conditions use the funct3 encoding directly
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_e;

  // Next-PC source
  typedef enum logic [1:0] {
    pc_seq    = 2'd0,
    pc_branch = 2'd1,
    pc_jal    = 2'd2,
    pc_jalr   = 2'd3
  } pc_sel_e;

  // Register write-back source
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_load = 2'd1,
    wb_link = 2'd2   // Return address for JAL and JALR
  } wb_sel_e;

endpackage

// File: rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
  input  logic [rv_core_pkg::xlen-1:0]       insn,
  output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_core_pkg::reg_addr_w-1:0] rd,
  output logic [rv_core_pkg::xlen-1:0]       imm,
  output logic                               use_imm,
  output rv_core_pkg::alu_op_e               alu_op,
  output rv_core_pkg::br_cond_e              br_cond,
  output rv_core_pkg::pc_sel_e               pc_sel,
  output rv_core_pkg::wb_sel_e               wb_sel,
  output logic                               rf_we,
  output logic                               store,
  output logic                               halt
);
  import rv_core_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_u;

  // Shared by the register-immediate and register-register groups
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3,
                                              input logic       sub_en,
                                              input logic       sra_en);
    alu_op_e op;
    case (f3)
      3'b000:  op = sub_en ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = sra_en ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // Sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign br_cond = br_cond_e'(funct3);

  always_comb begin
    imm     = imm_i;
    use_imm = 1'b0;
    alu_op  = alu_add;
    pc_sel  = pc_seq;
    wb_sel  = wb_alu;
    rf_we   = 1'b0;
    store   = 1'b0;
    halt    = 1'b0;

    case (opcode)
      op_lui: begin
        imm     = imm_u;
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
        rf_we   = 1'b1;
      end
      op_reg_imm: begin
        use_imm = 1'b1;
        alu_op  = alu_from_funct3(funct3, 1'b0, insn[30]);
        rf_we   = 1'b1;
      end
      op_reg_reg: begin
        alu_op = alu_from_funct3(funct3, insn[30], insn[30]);
        // M extension encodings leave rd untouched
        rf_we  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      end
      op_load: begin
        use_imm = 1'b1;                    // Address is rs1 + imm
        wb_sel  = wb_load;
        rf_we   = (funct3 == 3'b010);      // LW only
      end
      op_store: begin
        imm     = imm_s;
        use_imm = 1'b1;
        store   = (funct3 == 3'b010);      // SW only
      end
      op_branch: begin
        imm    = imm_b;
        pc_sel = pc_branch;
      end
      op_jal: begin
        imm    = imm_j;
        pc_sel = pc_jal;
        wb_sel = wb_link;
        rf_we  = 1'b1;
      end
      op_jalr: begin
        use_imm = 1'b1;                    // ALU forms the target
        pc_sel  = pc_jalr;
        wb_sel  = wb_link;
        rf_we   = 1'b1;
      end
      op_environ: begin
        halt = (insn[31:7] == 25'd0);      // ECALL
      end
      default: begin
        // FENCE and unknown opcodes just advance the PC
      end
    endcase
  end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               we,
  input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_core_pkg::reg_addr_w-1:0] raddr1,
  input  logic [rv_core_pkg::reg_addr_w-1:0] raddr2,
  input  logic [rv_core_pkg::xlen-1:0]       wdata,
  output logic [rv_core_pkg::xlen-1:0]       rdata1,
  output logic [rv_core_pkg::xlen-1:0]       rdata2
);
  import rv_core_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin  // x0 is never written
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads with x0 forced to zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
  input  rv_core_pkg::alu_op_e         op,
  input  logic [rv_core_pkg::xlen-1:0] a,
  input  logic [rv_core_pkg::xlen-1:0] b,
  output logic [rv_core_pkg::xlen-1:0] result
);
  import rv_core_pkg::*;

  logic            sub_mode;
  logic [xlen-1:0] b_eff;
  logic [xlen:0]   sum_full;
  logic [xlen-1:0] sum;
  logic            carry;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [4:0]      shamt;

  // One adder serves add, sub and both compares
  assign sub_mode = (op == alu_sub) || (op == alu_slt) || (op == alu_sltu);
  assign b_eff    = sub_mode ? ~b : b;
  assign sum_full = {1'b0, a} + {1'b0, b_eff} + {{xlen{1'b0}}, sub_mode};
  assign sum      = sum_full[xlen-1:0];
  assign carry    = sum_full[xlen];

  assign lt_unsigned = ~carry;  // Borrow out of a - b
  // Differing signs decide directly, otherwise the difference sign does
  assign lt_signed   = (a[xlen-1] ^ b[xlen-1]) ? a[xlen-1] : sum[xlen-1];

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add,
      alu_sub:    result = sum;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;          // LUI
      default:    result = sum;
    endcase
  end

endmodule

// File: rv_pc_unit.sv
`timescale 1ns/1ns

module rv_pc_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  rv_core_pkg::pc_sel_e         pc_sel,
  input  rv_core_pkg::br_cond_e        br_cond,
  input  logic [rv_core_pkg::xlen-1:0] rs1_val,
  input  logic [rv_core_pkg::xlen-1:0] rs2_val,
  input  logic [rv_core_pkg::xlen-1:0] imm,
  input  logic [rv_core_pkg::xlen-1:0] jalr_base,
  output logic [rv_core_pkg::xlen-1:0] pc
);
  import rv_core_pkg::*;

  logic            taken;
  logic [xlen-1:0] pc_plus_step;
  logic [xlen-1:0] pc_plus_imm;
  logic [xlen-1:0] pc_next;

  always_comb begin
    case (br_cond)
      br_eq:   taken = (rs1_val == rs2_val);
      br_ne:   taken = (rs1_val != rs2_val);
      br_lt:   taken = $signed(rs1_val) < $signed(rs2_val);
      br_ge:   taken = $signed(rs1_val) >= $signed(rs2_val);
      br_ltu:  taken = rs1_val < rs2_val;
      br_geu:  taken = rs1_val >= rs2_val;
      default: taken = 1'b0;  // Reserved funct3 never branches
    endcase
  end

  assign pc_plus_step = pc + xlen'(insn_step);
  assign pc_plus_imm  = pc + imm;

  always_comb begin
    case (pc_sel)
      pc_branch: pc_next = taken ? pc_plus_imm : pc_plus_step;
      pc_jal:    pc_next = pc_plus_imm;
      pc_jalr:   pc_next = {jalr_base[xlen-1:1], 1'b0};  // Bit 0 cleared
      default:   pc_next = pc_plus_step;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/1ns

module rv_core (
  input  logic                         clk,
  input  logic                         rst,
  output logic                         halt,
  output logic [rv_core_pkg::xlen-1:0] pc_to_imem,
  input  logic [rv_core_pkg::xlen-1:0] insn_from_imem,
  output logic [rv_core_pkg::xlen-1:0] addr_to_dmem,
  input  logic [rv_core_pkg::xlen-1:0] load_data_from_dmem,
  output logic [rv_core_pkg::xlen-1:0] store_data_to_dmem,
  output logic [3:0]                   store_we_to_dmem
);
  import rv_core_pkg::*;

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  logic                  use_imm;
  alu_op_e               alu_op;
  br_cond_e              br_cond;
  pc_sel_e               pc_sel;
  wb_sel_e               wb_sel;
  logic                  rf_we;
  logic                  rf_we_live;
  logic                  store;
  logic [xlen-1:0]       rs1_val;
  logic [xlen-1:0]       rs2_val;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       link;
  logic [xlen-1:0]       wb_data;

  rv_decoder u_decoder (
    .insn    (insn_from_imem),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .imm     (imm),
    .use_imm (use_imm),
    .alu_op  (alu_op),
    .br_cond (br_cond),
    .pc_sel  (pc_sel),
    .wb_sel  (wb_sel),
    .rf_we   (rf_we),
    .store   (store),
    .halt    (halt)
  );

  assign rf_we_live = rf_we && !rst;  // No writes while in reset

  rv_regfile u_regfile (
    .clk    (clk),
    .rst    (rst),
    .we     (rf_we_live),
    .waddr  (rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_val),
    .rdata2 (rs2_val)
  );

  assign alu_b = use_imm ? imm : rs2_val;

  rv_alu u_alu (
    .op     (alu_op),
    .a      (rs1_val),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk       (clk),
    .rst       (rst),
    .pc_sel    (pc_sel),
    .br_cond   (br_cond),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .imm       (imm),
    .jalr_base (alu_result),  // rs1 + imm for JALR
    .pc        (pc_to_imem)
  );

  assign link = pc_to_imem + xlen'(insn_step);

  always_comb begin
    case (wb_sel)
      wb_load: wb_data = load_data_from_dmem;
      wb_link: wb_data = link;
      default: wb_data = alu_result;
    endcase
  end

  // Word-only data port
  assign addr_to_dmem       = alu_result;
  assign store_data_to_dmem = rs2_val;
  assign store_we_to_dmem   = (store && !rst) ? 4'b1111 : 4'b0000;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  localparam int half_period  = 20;  // 40 ns clock
  localparam int reset_cycles = 3;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // Released on a falling edge
  end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core;
  localparam int          max_cycles  = 400;
  localparam int          num_groups  = 6;
  localparam logic [31:0] preset_word = 32'hC0FF_EE42;
  localparam logic [6:0]  op_imm      = 7'b0010011;
  // One {alt, funct3} nibble per register-register op with entry 0 lowest
  localparam logic [39:0] rr_codes    = 40'h76D5432180;
  localparam logic [23:0] br_f3s      = 24'h765410;  // Branch funct3 values

  logic        clk;
  logic        rst;
  logic        halt;
  logic [31:0] pc_to_imem;
  logic [31:0] insn_from_imem;
  logic [31:0] addr_to_dmem;
  logic [31:0] load_data_from_dmem;
  logic [31:0] store_data_to_dmem;
  logic [3:0]  store_we_to_dmem;

  // Program table, one row per instruction word
  logic [31:0] imem [128];
  logic        chk [128];  // Row must produce a store
  logic [31:0] ea [128];
  logic [31:0] ed [128];
  logic [31:0] nxt [128];  // Expected PC after this row
  int          grp [128];
  int          n_rows;
  int          ecall_row;
  int          st_off;
  int          bgrp;
  logic [31:0] dmem [64];
  logic [15:0] lfsr = 16'd95;
  int          n_checks [num_groups];
  int          n_errors [num_groups];
  int          cur_grp;
  int          next_report;
  logic [31:0] expect_pc;
  logic        done;

  tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

  rv_core DUT (
    .clk                 (clk),
    .rst                 (rst),
    .halt                (halt),
    .pc_to_imem          (pc_to_imem),
    .insn_from_imem      (insn_from_imem),
    .addr_to_dmem        (addr_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .store_we_to_dmem    (store_we_to_dmem)
  );

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Expected ALU result from the ISA definition
  function automatic logic [31:0] rr_ref(input logic [3:0] code, input logic [31:0] a,
                                         input logic [31:0] b);
    case (code)
      4'h0:    return a + b;
      4'h8:    return a - b;
      4'h1:    return a << b[4:0];
      4'h2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4'h3:    return (a < b) ? 32'd1 : 32'd0;
      4'h4:    return a ^ b;
      4'h5:    return a >> b[4:0];
      4'hD:    return $signed(a) >>> b[4:0];
      4'h6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic string group_name(input int g);
    case (g)
      0:       return "reset";
      1:       return "alu";
      2:       return "branch";
      3:       return "jump";
      4:       return "load_fence";
      default: return "ecall";
    endcase
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic put(input logic [31:0] insn, input logic [31:0] next_pc);
    imem[n_rows] = insn;
    chk[n_rows]  = 1'b0;
    nxt[n_rows]  = next_pc;
    grp[n_rows]  = bgrp;
    n_rows++;
  endtask

  task automatic emit(input logic [31:0] insn);
    put(insn, 32'(4 * n_rows + 4));
  endtask

  // SW rs2 into the next free word above the base held in x5
  task automatic store_row(input logic [4:0] rs2, input logic [31:0] data);
    put(enc_s(12'(st_off), rs2, 5'd5), 32'(4 * n_rows + 4));
    chk[n_rows-1] = 1'b1;
    ea[n_rows-1]  = 32'h80 + st_off;
    ed[n_rows-1]  = data;
    st_off += 4;
  endtask

  task automatic skipped_row();
    put(enc_s(12'(st_off), 5'd0, 5'd5), 32'd0);  // Must never be fetched
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] lui_v;
    logic [31:0] pc_r;
    logic [3:0]  code;
    logic [2:0]  f3;
    logic [4:0]  rs_a;
    logic [4:0]  rs_b;
    logic        taken;
    n_rows = 0;
    st_off = 0;
    bgrp   = 1;
    lui_v  = 32'hFEDC_B000;
    emit(enc_i(12'h080, 5'd0, 3'b000, 5'd5, op_imm));  // Store base
    rand_bits(12, a);
    rand_bits(12, b);
    a = {{20{a[11]}}, a[11:0]};
    b = {{20{b[11]}}, b[11:0]};
    emit(enc_i(a[11:0], 5'd0, 3'b000, 5'd1, op_imm));
    emit(enc_i(b[11:0], 5'd0, 3'b000, 5'd2, op_imm));
    store_row(5'd1, a);
    store_row(5'd2, b);
    emit({lui_v[31:12], 5'd6, 7'b0110111});  // LUI x6
    store_row(5'd6, lui_v);
    for (int k = 0; k < 10; k++) begin
      code = rr_codes[4*k +: 4];
      emit({code[3] ? 7'h20 : 7'h00, 5'd2, 5'd1, code[2:0], 5'd7, 7'b0110011});
      store_row(5'd7, rr_ref(code, a, b));
    end
    // Immediate shifts take shamt from the immediate
    emit(enc_i(12'h007, 5'd1, 3'b001, 5'd8, op_imm));
    store_row(5'd8, rr_ref(4'h1, a, 32'd7));
    emit(enc_i(12'h009, 5'd6, 3'b101, 5'd8, op_imm));
    store_row(5'd8, rr_ref(4'h5, lui_v, 32'd9));
    emit(enc_i(12'h409, 5'd6, 3'b101, 5'd8, op_imm));
    store_row(5'd8, rr_ref(4'hD, lui_v, 32'd9));

    bgrp = 2;
    emit(enc_i(12'hFFB, 5'd0, 3'b000, 5'd11, op_imm));  // x11 = -5
    emit(enc_i(12'h003, 5'd0, 3'b000, 5'd12, op_imm));
    emit(enc_i(12'h003, 5'd0, 3'b000, 5'd13, op_imm));
    for (int f = 0; f < 6; f++) begin
      for (int p = 0; p < 3; p++) begin
        f3    = br_f3s[4*f +: 3];
        rs_a  = (p == 1) ? 5'd11 : 5'd12;
        rs_b  = 5'd13 - 5'(p);
        taken = br_ref(f3, (rs_a == 5'd11) ? 32'hFFFF_FFFB : 32'd3,
                       (rs_b == 5'd11) ? 32'hFFFF_FFFB : 32'd3);
        put(enc_b(13'd8, rs_b, rs_a, f3), 32'(4 * n_rows + (taken ? 8 : 4)));
        if (taken) begin
          skipped_row();
        end else begin
          store_row(5'd12, 32'd3);
        end
      end
    end

    bgrp = 3;
    pc_r = 32'(4 * n_rows);
    put(enc_j(21'd12, 5'd14), pc_r + 32'd12);  // JAL x14, +12
    skipped_row();
    skipped_row();
    store_row(5'd14, pc_r + 32'd4);
    pc_r = 32'(4 * n_rows + 4);  // Address of the JALR
    emit(enc_i(12'(pc_r + 32'd13), 5'd0, 3'b000, 5'd15, op_imm));  // Odd target
    put(enc_i(12'h000, 5'd15, 3'b000, 5'd16, 7'b1100111), (pc_r + 32'd13) & ~32'd1);
    skipped_row();
    skipped_row();
    store_row(5'd16, pc_r + 32'd4);
    emit(enc_i(12'h5A5, 5'd0, 3'b000, 5'd0, op_imm));
    store_row(5'd0, 32'd0);

    bgrp = 4;
    emit(enc_i(12'h010, 5'd0, 3'b010, 5'd17, 7'b0000011));  // LW x17, 16(x0)
    emit(32'h0FF0_000F);                                    // FENCE
    store_row(5'd17, preset_word);

    bgrp      = 5;
    ecall_row = n_rows;
    emit(32'h0000_0073);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    n_checks[cur_grp]++;
    assert (got === exp) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      n_errors[cur_grp]++;
    end
  endtask

  task automatic report_upto(input int g);
    while (next_report < g) begin
      $display("Test %0d (%s): %0d checks, %0d errors", next_report,
               group_name(next_report), n_checks[next_report], n_errors[next_report]);
      next_report++;
    end
  endtask

  task automatic check_cycle();
    int unsigned idx;
    idx = pc_to_imem >> 2;
    if (idx < n_rows && grp[idx] > cur_grp) begin
      report_upto(grp[idx]);
      cur_grp = grp[idx];
    end
    check_val("pc_to_imem", pc_to_imem, expect_pc);
    n_checks[cur_grp]++;
    assert (idx < n_rows) else begin
      $display("Fetch at pc %h lies outside the program", pc_to_imem);
      n_errors[cur_grp]++;
    end
    if (idx >= n_rows) begin
      done = 1'b1;
    end else begin
      if (chk[idx]) begin
        check_val("store_we_to_dmem", store_we_to_dmem, 32'hF);
        check_val("addr_to_dmem", addr_to_dmem, ea[idx]);
        check_val("store_data_to_dmem", store_data_to_dmem, ed[idx]);
      end else begin
        check_val("store_we_to_dmem", store_we_to_dmem, 32'h0);
      end
      if (store_we_to_dmem == 4'hF) begin
        dmem[addr_to_dmem[7:2]] = store_data_to_dmem;
      end
      check_val("halt", halt, 32'(idx == ecall_row));
      done      = (halt === 1'b1);
      expect_pc = nxt[idx];
    end
  endtask

  initial begin
    logic started;
    int   tot_chk;
    int   tot_err;
    insn_from_imem      = enc_s(12'h000, 5'd0, 5'd0);  // SW on the bus while in reset
    load_data_from_dmem = 32'd0;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = 32'h5A00_0000 | (i << 2);  // Word tagged with its byte address
    end
    dmem[4]     = preset_word;
    started     = 1'b0;
    done        = 1'b0;
    cur_grp     = 0;
    next_report = 0;
    expect_pc   = 32'd0;
    build_program();
    #1;
    check_val("store_we_to_dmem", store_we_to_dmem, 32'h0);

    for (int cyc = 0; cyc < max_cycles && !done; cyc++) begin
      @(negedge clk);
      insn_from_imem = ((pc_to_imem >> 2) < n_rows) ? imem[pc_to_imem >> 2] : 32'h0000_0013;
      #1;
      load_data_from_dmem = dmem[addr_to_dmem[7:2]];  // Address has settled by now
      #1;
      if (rst || !started) begin
        check_val("pc_to_imem", pc_to_imem, 32'd0);
        check_val("store_we_to_dmem", store_we_to_dmem, 32'h0);
      end
      if (!rst) begin
        started = 1'b1;
        check_cycle();
      end
    end

    if (!done) begin
      $display("Timeout: the core did not halt within %0d cycles", max_cycles);
      n_errors[cur_grp]++;
    end
    report_upto(num_groups);
    tot_chk = 0;
    tot_err = 0;
    for (int g = 0; g < num_groups; g++) begin
      tot_chk += n_checks[g];
      tot_err += n_errors[g];
    end
    $display("Summary: %0d checks, %0d errors", tot_chk, tot_err);
    if (tot_err == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: rv_core.f
rv_core_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
tb_clock_gen.sv
tb_rv_core.sv
